// File: logic/bridgePkg.sv
`default_nettype none

package bridgePkg;

	// ----------------------------------------
	// bus widths and address map
	localparam int dataWidth = 32;
	localparam int numSlaves = 3;
	localparam int regIndexWidth = 4;
	localparam int numRegs = 2 ** regIndexWidth;
	localparam logic [dataWidth-1:0] slaveBase = 32'h8000_0000;
	localparam logic [dataWidth-1:0] slaveSpan = 32'h0400_0000;

	localparam logic [1:0] htransNonseq = 2'b10;
	localparam logic [1:0] htransSeq = 2'b11;

	// ----------------------------------------
	// controller states and request types
	typedef enum logic [2:0] {
		stIdle,
		stWriteWait,
		stRead,
		stWrite,
		stWritePipe,
		stReadEnable,
		stWriteEnable,
		stWriteEnablePipe
	} apbState;

	typedef struct packed {
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
		logic write;
	} ahbReq;

	typedef struct packed {
		logic [dataWidth-1:0] paddr;
		logic [dataWidth-1:0] pwdata;
		logic pwrite;
		logic [numSlaves-1:0] psel;
		logic penable;
	} apbReq;

	// one-hot region select, zero outside the window.
	function automatic logic [numSlaves-1:0] slaveSelect(input logic [dataWidth-1:0] addr);
		logic [numSlaves-1:0] sel;
		logic [dataWidth-1:0] lo;
		sel = '0;
		lo = slaveBase;
		for (int i = 0; i < numSlaves; i++)
		begin
			sel[i] = (addr >= lo) && (addr < lo + slaveSpan);
			lo = lo + slaveSpan;
		end
		return sel;
	endfunction

endpackage

`default_nettype wire

// File: logic/ahbSlaveIf.sv
`default_nettype none

module ahbSlaveIf (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire logic [bridgePkg::dataWidth-1:0] Haddr,
	input wire logic [bridgePkg::dataWidth-1:0] Hwdata,
	input wire logic Hwrite,
	input wire logic [1:0] Htrans,
	input wire logic Hreadyin,
	output logic valid,
	output bridgePkg::ahbReq curReq,
	output bridgePkg::ahbReq pipeReq1,
	output bridgePkg::ahbReq pipeReq2,
	output logic hwriteReg,
	output logic [bridgePkg::numSlaves-1:0] tempSel
);
	import bridgePkg::*;

	logic transActive;

	// ----------------------------------------
	// current address phase and decode
	assign curReq = '{addr: Haddr, wdata: Hwdata, write: Hwrite};

	assign tempSel = slaveSelect(Haddr);
	assign transActive = (Htrans == htransNonseq) || (Htrans == htransSeq); // IDLE and BUSY ignored.
	assign valid = Hreadyin && transActive && (|tempSel);

	// ----------------------------------------
	// two-deep pipeline, shifts every cycle
	always_ff @(posedge Hclk)
	begin
		pipeReq1 <= curReq; // address of last cycle, its data arrives now.
		pipeReq2 <= pipeReq1;
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			hwriteReg <= 1'b0;
		else
			hwriteReg <= Hwrite;
	end

	// the decoder never picks two peripherals.
	assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(tempSel));

endmodule

`default_nettype wire

// File: logic/apbFsmController.sv
`default_nettype none

module apbFsmController (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire logic valid,
	input wire bridgePkg::ahbReq curReq,
	input wire bridgePkg::ahbReq pipeReq1,
	input wire bridgePkg::ahbReq pipeReq2,
	input wire logic hwriteReg,
	input wire logic [bridgePkg::numSlaves-1:0] tempSel,
	input wire logic [bridgePkg::dataWidth-1:0] Hwdata,
	output bridgePkg::apbReq apb,
	output logic Hreadyout
);
	import bridgePkg::*;

	apbState state;
	apbState nextState;
	apbReq nextApb;
	logic nextReady;
	logic accept;

	// an address phase only completes while we drive Hreadyout high.
	assign accept = valid && Hreadyout;

	// ----------------------------------------
	// next state and next outputs
	always_comb
	begin
		nextState = state;
		nextApb = apb;
		nextApb.penable = 1'b0;
		nextReady = 1'b1;
		case (state)
			stIdle, stReadEnable, stWriteEnable:
			begin
				nextState = stIdle;
				nextApb.psel = '0;
				if (accept && curReq.write)
				begin
					nextState = stWriteWait; // wait for the data phase.
				end
				else if (accept)
				begin
					nextState = stRead;
					nextApb.paddr = curReq.addr;
					nextApb.pwrite = 1'b0;
					nextApb.psel = tempSel;
					nextReady = 1'b0; // hold the data phase until ENABLE.
				end
			end
			stWriteWait:
			begin
				nextApb.paddr = pipeReq1.addr;
				nextApb.pwdata = Hwdata;
				nextApb.pwrite = 1'b1;
				nextApb.psel = slaveSelect(pipeReq1.addr);
				nextReady = 1'b0;
				nextState = accept ? stWritePipe : stWrite;
			end
			stRead:
			begin
				nextApb.penable = 1'b1;
				nextState = stReadEnable;
			end
			stWrite:
			begin
				nextApb.penable = 1'b1;
				nextState = stWriteEnable;
			end
			stWritePipe:
			begin
				nextApb.penable = 1'b1;
				nextReady = hwriteReg; // a pending read waits for its own ENABLE.
				nextState = stWriteEnablePipe;
			end
			stWriteEnablePipe:
			begin
				// pending transfer was accepted two cycles ago.
				nextApb.paddr = pipeReq2.addr;
				nextApb.pwdata = pipeReq1.wdata;
				nextApb.pwrite = pipeReq2.write;
				nextApb.psel = slaveSelect(pipeReq2.addr);
				nextReady = 1'b0;
				if (!pipeReq2.write)
					nextState = stRead;
				else if (accept)
					nextState = stWritePipe;
				else
					nextState = stWrite;
			end
			default:
			begin
				nextState = stIdle;
				nextApb.psel = '0;
			end
		endcase
	end

	// ----------------------------------------
	// registered outputs
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= stIdle;
			apb.psel <= '0;
			apb.penable <= 1'b0;
			apb.pwrite <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			state <= nextState;
			apb <= nextApb;
			Hreadyout <= nextReady;
		end
	end

	// ENABLE comes only straight after a SETUP to the same peripheral.
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		apb.penable |-> !$past(apb.penable) && (|apb.psel) && (apb.psel == $past(apb.psel)));

	assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(apb.psel));

endmodule

`default_nettype wire

// File: logic/apbRegBank.sv
`default_nettype none

module apbRegBank (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire bridgePkg::apbReq apb,
	input wire logic sel,
	output logic [bridgePkg::dataWidth-1:0] rdata
);
	import bridgePkg::*;

	logic [dataWidth-1:0] regs [numRegs];
	logic [regIndexWidth-1:0] index;

	assign index = apb.paddr[regIndexWidth+1:2]; // word addressed.

	// ----------------------------------------
	// register file
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int i = 0; i < numRegs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (sel && apb.penable && apb.pwrite)
		begin
			regs[index] <= apb.pwdata;
		end
	end

	// zero wait states, read word is there as soon as we are selected.
	assign rdata = sel ? regs[index] : '0;

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		(sel && apb.penable) |-> $stable(apb.paddr));

endmodule

`default_nettype wire

// File: logic/bridgeTop.sv
`default_nettype none

module bridgeTop (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire logic [bridgePkg::dataWidth-1:0] Haddr,
	input wire logic [bridgePkg::dataWidth-1:0] Hwdata,
	input wire logic Hwrite,
	input wire logic [1:0] Htrans,
	input wire logic Hreadyin,
	output logic Hreadyout,
	output logic [bridgePkg::dataWidth-1:0] Hrdata
);
	import bridgePkg::*;

	logic valid;
	ahbReq curReq;
	ahbReq pipeReq1;
	ahbReq pipeReq2;
	logic hwriteReg;
	logic [numSlaves-1:0] tempSel;
	apbReq apb;
	logic [dataWidth-1:0] bankRdata [numSlaves];
	logic [dataWidth-1:0] Prdata;

	ahbSlaveIf frontEnd (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hwrite(Hwrite),
		.Htrans(Htrans),
		.Hreadyin(Hreadyin),
		.valid(valid),
		.curReq(curReq),
		.pipeReq1(pipeReq1),
		.pipeReq2(pipeReq2),
		.hwriteReg(hwriteReg),
		.tempSel(tempSel)
	);

	apbFsmController controller (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.valid(valid),
		.curReq(curReq),
		.pipeReq1(pipeReq1),
		.pipeReq2(pipeReq2),
		.hwriteReg(hwriteReg),
		.tempSel(tempSel),
		.Hwdata(Hwdata),
		.apb(apb),
		.Hreadyout(Hreadyout)
	);

	// ----------------------------------------
	// peripherals and read return
	for (genvar i = 0; i < numSlaves; i++)
	begin : gBank
		apbRegBank bank (
			.Hclk(Hclk),
			.Hresetn(Hresetn),
			.apb(apb),
			.sel(apb.psel[i]),
			.rdata(bankRdata[i])
		);
	end

	always_comb
	begin
		Prdata = '0;
		for (int i = 0; i < numSlaves; i++)
		begin
			if (apb.psel[i])
				Prdata = Prdata | bankRdata[i];
		end
	end

	assign Hrdata = Prdata;

endmodule

`default_nettype wire

// File: bench/clockGen.sv
`default_nettype none

module clockGen (
	output logic Hclk,
	output logic Hresetn
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 3;

	initial
	begin
		Hclk = 1'b0;
		forever
			#10 Hclk = ~Hclk; // 20 ns period.
	end

	initial
	begin
		Hresetn = 1'b0;
		repeat (resetCycles) @(posedge Hclk);
		Hresetn <= 1'b1; // released on a rising edge.
	end

endmodule

`default_nettype wire

// File: bench/bridgeTb.sv
`default_nettype none

module bridgeTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] windowBase = 32'h8000_0000;
	localparam logic [31:0] regionSize = 32'h0400_0000;
	localparam logic [31:0] windowEnd = 32'h8C00_0000;
	localparam int bankCount = 3;
	localparam int wordCount = 16;
	localparam int readyTimeout = 50;
	localparam logic [1:0] transIdle = 2'b00;
	localparam logic [1:0] transBusy = 2'b01;
	localparam logic [1:0] transNonseq = 2'b10;
	localparam logic [1:0] transSeq = 2'b11;

	logic Hclk;
	logic Hresetn;
	logic [31:0] Haddr;
	logic [31:0] Hwdata;
	logic Hwrite;
	logic [1:0] Htrans;
	logic Hreadyin;
	logic Hreadyout;
	logic [31:0] Hrdata;

	logic [31:0] shadow [bankCount][wordCount]; // expected bank contents.
	logic readPending;
	logic [31:0] readAddr;
	int errorCount;

	clockGen clocks (
		.Hclk(Hclk),
		.Hresetn(Hresetn)
	);

	bridgeTop UUT (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hwrite(Hwrite),
		.Htrans(Htrans),
		.Hreadyin(Hreadyin),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata)
	);

	// ----------------------------------------
	// reference model
	function automatic logic inWindow(input logic [31:0] addr);
		return (addr >= windowBase) && (addr < windowEnd);
	endfunction

	function automatic int bankOf(input logic [31:0] addr);
		return (addr - windowBase) / regionSize;
	endfunction

	function automatic logic [31:0] refRead(input logic [31:0] addr);
		if (!inWindow(addr))
			return '0;
		return shadow[bankOf(addr)][addr[5:2]];
	endfunction

	function automatic logic [31:0] regAddr(input int bank, input int index);
		return windowBase + bank * regionSize + (index << 2);
	endfunction

	function automatic logic [31:0] randomAddr();
		logic [31:0] bank;
		bank = $urandom_range(bankCount - 1, 0);
		return windowBase + bank * regionSize + ($urandom & (regionSize - 4)); // any word in region.
	endfunction

	// ----------------------------------------
	// checks and waits
	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, actual, expected);
			$display("Errors found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic stopOnTimeout(input string what);
		errorCount++;
		$display("timeout while waiting, %s", what);
		$display("Errors found");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic waitReset();
		int cycles;
		cycles = 0;
		@(negedge Hclk);
		while (!Hresetn)
		begin
			cycles++;
			if (cycles > readyTimeout)
				stopOnTimeout("the reset was never released");
			@(negedge Hclk);
		end
		@(posedge Hclk);
	endtask

	task automatic waitReady();
		int cycles;
		cycles = 0;
		@(negedge Hclk);
		while (!Hreadyout)
		begin
			cycles++;
			if (cycles > readyTimeout)
				stopOnTimeout("the bridge never became ready");
			@(negedge Hclk);
		end
	endtask

	// compares each read at the end of its data phase.
	always @(negedge Hclk)
	begin
		if (Hresetn && Hreadyout && readPending)
			checkValue("Hrdata", Hrdata, refRead(readAddr));
	end

	// ----------------------------------------
	// AHB master
	task automatic issue(input logic [1:0] trans, input logic write, input logic [31:0] addr,
		input logic [31:0] wdata);
		logic active;
		logic taken;
		active = Hreadyin && (trans == transNonseq || trans == transSeq);
		taken = active && inWindow(addr);
		Htrans <= trans;
		Haddr <= addr;
		Hwrite <= write;
		waitReady(); // address phase held while Hreadyout is low.
		@(posedge Hclk);
		readPending = active && !write; // reads outside the window return zero.
		readAddr = addr;
		if (write)
			Hwdata <= wdata; // data phase follows the address.
		if (taken && write)
			shadow[bankOf(addr)][addr[5:2]] = wdata;
	endtask

	task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
		issue(transNonseq, 1'b1, addr, data);
	endtask

	task automatic readWord(input logic [31:0] addr);
		issue(transNonseq, 1'b0, addr, '0);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) issue(transIdle, 1'b0, 32'h0, '0);
	endtask

	task automatic readAll();
		for (int b = 0; b < bankCount; b++)
		begin
			for (int r = 0; r < wordCount; r++)
				readWord(regAddr(b, r));
		end
		idle(3);
	endtask

	// bus must stay ready while nothing is accepted.
	task automatic holdNoTransfer(input logic [1:0] trans, input logic readyIn, input int cycles);
		Htrans <= trans;
		Hreadyin <= readyIn;
		Hwrite <= 1'b1;
		Haddr <= randomAddr();
		Hwdata <= $urandom;
		repeat (cycles)
		begin
			@(negedge Hclk);
			checkValue("Hreadyout", {31'b0, Hreadyout}, 32'h1);
			@(posedge Hclk);
		end
		Hreadyin <= 1'b1;
		Htrans <= transIdle;
	endtask

	// ----------------------------------------
	// test sequence
	initial
	begin
		logic [31:0] addr;
		errorCount = 0;
		readPending = 1'b0;
		readAddr = '0;
		void'($urandom(32'h61de));
		for (int b = 0; b < bankCount; b++)
		begin
			for (int r = 0; r < wordCount; r++)
				shadow[b][r] = '0;
		end
		Haddr <= '0;
		Hwdata <= '0;
		Hwrite <= 1'b0;
		Htrans <= transIdle;
		Hreadyin <= 1'b1;
		waitReset();

		readAll(); // everything is zero after reset.

		for (int b = 0; b < bankCount; b++)
		begin
			for (int r = 0; r < wordCount; r += 5)
			begin
				writeWord(regAddr(b, r), $urandom);
				idle(2);
			end
		end
		readAll();

		for (int i = 0; i < 24; i++)
			issue((i % 4 == 0) ? transNonseq : transSeq, 1'b1, randomAddr(), $urandom);
		idle(3);
		readAll();

		for (int i = 0; i < 16; i++)
		begin
			addr = randomAddr();
			writeWord(addr, $urandom);
			readWord(addr); // read right behind the write.
			readWord(randomAddr());
			writeWord(randomAddr(), $urandom);
		end
		idle(3);

		writeWord(32'h7FFF_FFFC, $urandom);
		writeWord(windowEnd, $urandom);
		writeWord(32'hFFFF_FFF0, $urandom);
		readWord(32'h0000_0040);
		issue(transIdle, 1'b1, randomAddr(), $urandom);
		issue(transIdle, 1'b1, regAddr(1, 5), $urandom);
		idle(2);
		readAll();

		holdNoTransfer(transBusy, 1'b1, 6);
		holdNoTransfer(transNonseq, 1'b0, 6);
		readAll();

		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
logic/bridgePkg.sv
logic/ahbSlaveIf.sv
logic/apbFsmController.sv
logic/apbRegBank.sv
logic/bridgeTop.sv
bench/clockGen.sv
bench/bridgeTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the AHB to APB bridge testbench with Verilator.

set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --Wno-fatal --timescale 1ns/100ps \
	-f project.f --top-module bridgeTb -Mdir "$buildDir" -o bridgeSim
if [ $? -ne 0 ]; then
	echo "verilator compile step failed"
	exit 1
fi

"./$buildDir/bridgeSim" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "Errors found" "$logFile"; then
	echo "simulation reported failures"
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi
exit 0
